// ==== common/ooo_config.svh ====
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// ----------------------------------------
// renaming bookkeeping sizes
// ----------------------------------------
`define OOO_REG_NUM        32   // integer registers, power of 2, x0 hard-wired
`define OOO_ROB_DEPTH      8    // in-flight instructions, power of 2
`define OOO_DATA_W         32   // result width
`define OOO_REGSTAT_CNT_W  4    // busy counter, must hold OOO_ROB_DEPTH writers

`endif

// ==== common/ooo_pkg.sv ====
`include "ooo_config.svh"

package ooo_pkg;

    // ----------------------------------------
    // indices and payload
    // ----------------------------------------
    typedef logic [$clog2(`OOO_REG_NUM)-1:0]   reg_idx_t;  // architectural register
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;  // rob tag, wraps with the pointers
    typedef logic [`OOO_DATA_W-1:0]            data_t;     // result value

    // one rob slot, done is set by writeback and cleared on allocation
    typedef struct packed {
        logic     done;   // result present
        reg_idx_t rd;     // destination of the instruction
        data_t    value;  // result, valid only once done
    } rob_entry_t;

endpackage

// ==== common/ooo_if.sv ====
`timescale 1ns/1ps

// issue side of the register status table
interface regstat_issue_if;
    import ooo_pkg::*;

    logic     valid;        // one-cycle issue pulse
    reg_idx_t rd;           // destination of the issuing instruction
    rob_idx_t rob_idx;      // tag being allocated (rob tail)
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     rs1_busy;     // rs1 still has an in-flight writer
    rob_idx_t rs1_rob_idx;  // newest writer of rs1
    logic     rs2_busy;
    rob_idx_t rs2_rob_idx;

    modport ctrl (
        output valid, rd, rob_idx, rs1, rs2,
        input  rs1_busy, rs1_rob_idx, rs2_busy, rs2_rob_idx
    );

    modport rs (
        input  valid, rd, rob_idx, rs1, rs2,
        output rs1_busy, rs1_rob_idx, rs2_busy, rs2_rob_idx
    );
endinterface

// commit side, shared by the status table and the rob
interface regstat_commit_if;
    import ooo_pkg::*;

    logic     valid;     // one-cycle pop pulse
    reg_idx_t rd;        // destination of the committing instruction
    rob_idx_t head_idx;  // rob slot leaving

    modport ctrl (output valid, rd, head_idx);
    modport rs   (input valid, rd, head_idx);
    modport rob  (input valid, rd, head_idx);
endinterface

// ==== regstat/updown_counter.sv ====
`timescale 1ns/1ps

module updown_counter #(
    parameter int unsigned W = 4
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         en_i,
    input  logic         clr_i,    // wins over en_i
    input  logic         up_dn_i,  // 1 counts up, 0 counts down
    output logic [W-1:0] count_o,
    output logic         tc_o      // next step in the current direction wraps
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin : cnt_reg
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0;
        end else if (en_i) begin
            if (up_dn_i) begin
                count_o <= count_o + 1'b1;
            end else begin
                count_o <= count_o - 1'b1;
            end
        end
    end

    // terminal count depends on direction
    assign tc_o = up_dn_i ? (&count_o) : ~(|count_o);

endmodule

// ==== regstat/int_regstat.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module int_regstat (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    regstat_issue_if.rs  issue,
    regstat_commit_if.rs commit
);
    import ooo_pkg::*;

    localparam int unsigned REG_NUM = `OOO_REG_NUM;
    localparam int unsigned CNT_W   = `OOO_REGSTAT_CNT_W;

    // ----------------------------------------
    // per-register state, x0 has none
    // ----------------------------------------
    rob_idx_t         tag_q    [1:REG_NUM-1];  // newest rob tag writing the register
    logic [CNT_W-1:0] cnt      [1:REG_NUM-1];  // in-flight writers
    logic             cnt_en   [1:REG_NUM-1];
    logic             cnt_up   [1:REG_NUM-1];
    logic             cnt_tc   [1:REG_NUM-1];
    logic             busy_vec [REG_NUM];      // full 0..N-1 view for the read ports
    rob_idx_t         tag_vec  [REG_NUM];
    logic             same_rd;                 // issue and commit hit the same rd

    assign same_rd = issue.valid && commit.valid && (issue.rd == commit.rd);

    // ----------------------------------------
    // counter control
    // ----------------------------------------
    always_comb begin : cnt_ctrl
        for (int i = 1; i < REG_NUM; i++) begin
            cnt_en[i] = 1'b0;
            cnt_up[i] = 1'b0;
        end
        // +1 and -1 on the same register cancel out
        if (!same_rd) begin
            if (issue.valid && (issue.rd != '0)) begin
                cnt_en[issue.rd] = 1'b1;
                cnt_up[issue.rd] = 1'b1;  // one more writer in flight
            end
            if (commit.valid && (commit.rd != '0)) begin
                cnt_en[commit.rd] = 1'b1; // oldest writer retires, count down
            end
        end
    end

    // newest tag, still updated when the counter update is skipped
    always_ff @(posedge clk_i or negedge rst_n_i) begin : tag_reg
        if (!rst_n_i) begin
            for (int i = 1; i < REG_NUM; i++) begin
                tag_q[i] <= '0;
            end
        end else if (flush_i) begin
            for (int i = 1; i < REG_NUM; i++) begin
                tag_q[i] <= '0;
            end
        end else if (issue.valid && (issue.rd != '0)) begin
            tag_q[issue.rd] <= issue.rob_idx;
        end
    end

    assign busy_vec[0] = 1'b0;  // x0 is never busy
    assign tag_vec[0]  = '0;

    for (genvar i = 1; i < REG_NUM; i++) begin : g_reg
        updown_counter #(
            .W (CNT_W)
        ) u_busy_cnt (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .en_i    (cnt_en[i]),
            .clr_i   (flush_i),
            .up_dn_i (cnt_up[i]),
            .count_o (cnt[i]),
            .tc_o    (cnt_tc[i])
        );

        assign busy_vec[i] = |cnt[i];
        assign tag_vec[i]  = tag_q[i];

        // a step at terminal count means over/underflow of the writer count
        a_cnt_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            !(cnt_en[i] && cnt_tc[i] && !flush_i))
            else $error("regstat: busy counter of x%0d wraps", i);

        // last writer leaving must be the rob head
        a_last_writer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            commit.valid && (commit.rd == i) && (cnt[i] == CNT_W'(1))
            |-> tag_q[i] == commit.head_idx)
            else $error("regstat: x%0d retires from a slot that is not its newest", i);
    end

    // ----------------------------------------
    // read ports, state before this issue
    // ----------------------------------------
    assign issue.rs1_busy    = busy_vec[issue.rs1];
    assign issue.rs1_rob_idx = tag_vec[issue.rs1];
    assign issue.rs2_busy    = busy_vec[issue.rs2];
    assign issue.rs2_rob_idx = tag_vec[issue.rs2];

endmodule

// ==== source/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module reorder_buffer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                alloc_i,
    input  ooo_pkg::reg_idx_t   alloc_rd_i,
    output ooo_pkg::rob_idx_t   tail_idx_o,
    output logic                full_o,
    output logic                empty_o,
    input  logic                wb_valid_i,
    input  ooo_pkg::rob_idx_t   wb_rob_idx_i,
    input  ooo_pkg::data_t      wb_data_i,
    output ooo_pkg::rob_entry_t head_entry_o,
    regstat_commit_if.rob       commit,
    output ooo_pkg::rob_idx_t   head_idx_o
);
    import ooo_pkg::*;

    localparam int unsigned DEPTH = `OOO_ROB_DEPTH;
    localparam int unsigned OCC_W = $clog2(DEPTH) + 1;  // holds 0..DEPTH

    rob_entry_t       rob_q [DEPTH];
    rob_idx_t         head_q;      // oldest in-flight entry
    rob_idx_t         tail_q;      // next free slot
    logic [OCC_W-1:0] occ_q;       // occupancy
    logic             pop;
    rob_idx_t         wb_ofs;      // distance of the written slot from head
    logic             wb_live;     // written slot is allocated

    assign pop = commit.valid;

    // ----------------------------------------
    // pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin : ptr_reg
        if (!rst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
            occ_q  <= '0;
        end else if (flush_i) begin
            head_q <= '0;  // tags restart at 0
            tail_q <= '0;
            occ_q  <= '0;
        end else begin
            if (alloc_i) begin
                tail_q <= tail_q + 1'b1;  // power-of-2 depth, wraps by itself
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_i, pop})
                2'b10:   occ_q <= occ_q + 1'b1;
                2'b01:   occ_q <= occ_q - 1'b1;
                default: occ_q <= occ_q;  // none, or one in and one out
            endcase
        end
    end

    // ----------------------------------------
    // entry storage
    // ----------------------------------------
    always_ff @(posedge clk_i) begin : entry_write
        if (alloc_i) begin
            rob_q[tail_q].done <= 1'b0;
            rob_q[tail_q].rd   <= alloc_rd_i;
        end
        if (wb_valid_i) begin  // never the tail slot when legal
            rob_q[wb_rob_idx_i].done  <= 1'b1;
            rob_q[wb_rob_idx_i].value <= wb_data_i;
        end
    end

    assign head_entry_o = rob_q[head_q];
    assign head_idx_o   = head_q;
    assign tail_idx_o   = tail_q;
    assign full_o       = (occ_q == OCC_W'(DEPTH));
    assign empty_o      = (occ_q == '0);

    assign wb_ofs  = wb_rob_idx_i - head_q;
    assign wb_live = ({1'b0, wb_ofs} < occ_q);

    a_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_i |-> !full_o)
        else $error("rob: allocation while full");

    a_wb_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_i |-> wb_live)
        else $error("rob: writeback to free slot %0d", wb_rob_idx_i);

endmodule

// ==== source/issue_commit_ctrl.sv ====
`timescale 1ns/1ps

module issue_commit_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                issue_req_i,
    input  ooo_pkg::reg_idx_t   issue_rd_i,
    input  ooo_pkg::reg_idx_t   issue_rs1_i,
    input  ooo_pkg::reg_idx_t   issue_rs2_i,
    output logic                issue_ack_o,
    output ooo_pkg::rob_idx_t   issue_rob_idx_o,
    output logic                issue_rs1_busy_o,
    output logic                issue_rs2_busy_o,
    output ooo_pkg::rob_idx_t   issue_rs1_rob_idx_o,
    output ooo_pkg::rob_idx_t   issue_rs2_rob_idx_o,
    output logic                commit_req_o,
    input  logic                commit_ack_i,
    output ooo_pkg::reg_idx_t   commit_rd_o,
    output ooo_pkg::data_t      commit_data_o,
    output logic                alloc_o,
    output ooo_pkg::reg_idx_t   alloc_rd_o,
    input  ooo_pkg::rob_idx_t   tail_idx_i,
    input  logic                full_i,
    input  logic                empty_i,
    input  ooo_pkg::rob_entry_t head_entry_i,
    input  ooo_pkg::rob_idx_t   head_idx_i,
    regstat_issue_if.ctrl       rs_issue,
    regstat_commit_if.ctrl      rs_commit
);
    import ooo_pkg::*;

    typedef enum logic [1:0] {IS_IDLE, IS_ALLOC, IS_ACK} issue_state_t;
    typedef enum logic [1:0] {CM_IDLE, CM_LOAD, CM_REQ, CM_WAIT} commit_state_t;

    issue_state_t  is_state_q, is_state_d;
    commit_state_t cm_state_q, cm_state_d;
    logic          req_q;       // sampled issue request
    logic          is_valid;    // allocate + regstat issue pulse
    logic          cm_valid;    // pop + regstat commit pulse
    logic          head_ready;  // head has its result

    // ----------------------------------------
    // issue handshake
    // ----------------------------------------
    always_comb begin : issue_fsm
        is_state_d = is_state_q;
        case (is_state_q)
            IS_IDLE:  if (req_q && !full_i) is_state_d = IS_ALLOC;  // waits out a full rob
            IS_ALLOC: is_state_d = IS_ACK;
            IS_ACK:   if (!req_q) is_state_d = IS_IDLE;             // ack drops after req
            default:  is_state_d = IS_IDLE;
        endcase
    end

    assign is_valid    = (is_state_q == IS_ALLOC);
    assign issue_ack_o = (is_state_q == IS_ACK);

    // operand status as seen before the new rd is recorded
    always_ff @(posedge clk_i) begin : issue_status
        if (is_valid) begin
            issue_rob_idx_o     <= tail_idx_i;
            issue_rs1_busy_o    <= rs_issue.rs1_busy;
            issue_rs1_rob_idx_o <= rs_issue.rs1_rob_idx;
            issue_rs2_busy_o    <= rs_issue.rs2_busy;
            issue_rs2_rob_idx_o <= rs_issue.rs2_rob_idx;
        end
    end

    // ----------------------------------------
    // commit handshake
    // ----------------------------------------
    assign head_ready = !empty_i && head_entry_i.done;

    always_comb begin : commit_fsm
        cm_state_d = cm_state_q;
        case (cm_state_q)
            CM_IDLE: if (head_ready) cm_state_d = CM_LOAD;     // rd/value captured here
            CM_LOAD: cm_state_d = CM_REQ;
            CM_REQ:  if (commit_ack_i) cm_state_d = CM_WAIT;   // pop in this cycle
            CM_WAIT: if (!commit_ack_i) cm_state_d = CM_IDLE;
            default: cm_state_d = CM_IDLE;
        endcase
    end

    assign commit_req_o = (cm_state_q == CM_REQ);
    assign cm_valid     = commit_req_o && commit_ack_i;

    always_ff @(posedge clk_i) begin : commit_payload
        if ((cm_state_q == CM_IDLE) && head_ready) begin
            commit_rd_o   <= head_entry_i.rd;
            commit_data_o <= head_entry_i.value;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : state_reg
        if (!rst_n_i) begin
            req_q      <= 1'b0;
            is_state_q <= IS_IDLE;
            cm_state_q <= CM_IDLE;
        end else begin
            req_q <= issue_req_i;
            if (flush_i) begin  // both handshakes back to idle
                is_state_q <= IS_IDLE;
                cm_state_q <= CM_IDLE;
            end else begin
                is_state_q <= is_state_d;
                cm_state_q <= cm_state_d;
            end
        end
    end

    // ----------------------------------------
    // datapath sequencing
    // ----------------------------------------
    assign alloc_o          = is_valid;
    assign alloc_rd_o       = issue_rd_i;
    assign rs_issue.valid   = is_valid;
    assign rs_issue.rd      = issue_rd_i;
    assign rs_issue.rob_idx = tail_idx_i;   // tag the rob hands out now
    assign rs_issue.rs1     = issue_rs1_i;
    assign rs_issue.rs2     = issue_rs2_i;

    assign rs_commit.valid    = cm_valid;
    assign rs_commit.rd       = commit_rd_o;
    assign rs_commit.head_idx = head_idx_i;

    a_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rs_commit.valid |-> !empty_i)
        else $error("ctrl: commit pulse with empty rob");

endmodule

// ==== source/ooo_core_top.sv ====
`timescale 1ns/1ps

module ooo_core_top (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    // issue, four-phase
    input  logic              issue_req_i,
    input  ooo_pkg::reg_idx_t issue_rd_i,
    input  ooo_pkg::reg_idx_t issue_rs1_i,
    input  ooo_pkg::reg_idx_t issue_rs2_i,
    output logic              issue_ack_o,
    output ooo_pkg::rob_idx_t issue_rob_idx_o,
    output logic              issue_rs1_busy_o,
    output ooo_pkg::rob_idx_t issue_rs1_rob_idx_o,
    output logic              issue_rs2_busy_o,
    output ooo_pkg::rob_idx_t issue_rs2_rob_idx_o,
    // writeback, single-cycle pulse
    input  logic              wb_valid_i,
    input  ooo_pkg::rob_idx_t wb_rob_idx_i,
    input  ooo_pkg::data_t    wb_data_i,
    // commit, four-phase
    output logic              commit_req_o,
    input  logic              commit_ack_i,
    output ooo_pkg::reg_idx_t commit_rd_o,
    output ooo_pkg::data_t    commit_data_o
);
    import ooo_pkg::*;

    logic       alloc;
    reg_idx_t   alloc_rd;
    rob_idx_t   tail_idx;
    rob_idx_t   head_idx;
    logic       full;
    logic       empty;
    rob_entry_t head_entry;

    regstat_issue_if  issue_if ();
    regstat_commit_if commit_if ();

    issue_commit_ctrl u_ctrl (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .issue_req_i         (issue_req_i),
        .issue_rd_i          (issue_rd_i),
        .issue_rs1_i         (issue_rs1_i),
        .issue_rs2_i         (issue_rs2_i),
        .issue_ack_o         (issue_ack_o),
        .issue_rob_idx_o     (issue_rob_idx_o),
        .issue_rs1_busy_o    (issue_rs1_busy_o),
        .issue_rs2_busy_o    (issue_rs2_busy_o),
        .issue_rs1_rob_idx_o (issue_rs1_rob_idx_o),
        .issue_rs2_rob_idx_o (issue_rs2_rob_idx_o),
        .commit_req_o        (commit_req_o),
        .commit_ack_i        (commit_ack_i),
        .commit_rd_o         (commit_rd_o),
        .commit_data_o       (commit_data_o),
        .alloc_o             (alloc),
        .alloc_rd_o          (alloc_rd),
        .tail_idx_i          (tail_idx),
        .full_i              (full),
        .empty_i             (empty),
        .head_entry_i        (head_entry),
        .head_idx_i          (head_idx),
        .rs_issue            (issue_if.ctrl),
        .rs_commit           (commit_if.ctrl)
    );

    reorder_buffer u_rob (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .alloc_i      (alloc),
        .alloc_rd_i   (alloc_rd),
        .tail_idx_o   (tail_idx),
        .full_o       (full),
        .empty_o      (empty),
        .wb_valid_i   (wb_valid_i),    // straight from the execution side
        .wb_rob_idx_i (wb_rob_idx_i),
        .wb_data_i    (wb_data_i),
        .head_entry_o (head_entry),
        .commit       (commit_if.rob),
        .head_idx_o   (head_idx)
    );

    int_regstat u_regstat (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .issue   (issue_if.rs),
        .commit  (commit_if.rs)
    );

endmodule

// ==== verification/tb_ooo_core.sv ====
`timescale 1ns/1ps
`include "ooo_config.svh"

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int DRIVE_DLY = 1;              // ns after the rising edge
    localparam int ISSUE_LAT = 3;              // req sample edge plus 2
    localparam int TIMEOUT   = 64;             // cycles allowed per wait
    localparam int WATCH_WIN = 4;              // cycles a blocked output is watched
    localparam int DEPTH     = `OOO_ROB_DEPTH;
    localparam logic [31:0] SEED = 32'h24e6_988c;

    logic     clk_i;
    logic     rst_n_i;
    logic     flush_i;
    logic     issue_req_i;
    reg_idx_t issue_rd_i;
    reg_idx_t issue_rs1_i;
    reg_idx_t issue_rs2_i;
    logic     issue_ack_o;
    rob_idx_t issue_rob_idx_o;
    logic     issue_rs1_busy_o;
    rob_idx_t issue_rs1_rob_idx_o;
    logic     issue_rs2_busy_o;
    rob_idx_t issue_rs2_rob_idx_o;
    logic     wb_valid_i;
    rob_idx_t wb_rob_idx_i;
    data_t    wb_data_i;
    logic     commit_req_o;
    logic     commit_ack_i;
    reg_idx_t commit_rd_o;
    data_t    commit_data_o;

    int   checks    = 0;
    int   errors    = 0;
    int   cycle_cnt = 0;   // free-running, for latency checks
    int   start_cyc;       // cycle at which issue req went high
    int   occ       = 0;   // expected rob occupancy
    int   hold_cnt  = 0;   // issues left while commit ack is held
    logic pending   = 1'b0; // last held issue waits for the next commit
    logic iss_full;        // rob expected full when the issue starts
    int   iss_rd, iss_rs1, iss_rs2;
    int   exp_tag, exp_b1, exp_t1, exp_b2, exp_t2;

    ooo_core_top dut_i (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .issue_req_i         (issue_req_i),
        .issue_rd_i          (issue_rd_i),
        .issue_rs1_i         (issue_rs1_i),
        .issue_rs2_i         (issue_rs2_i),
        .issue_ack_o         (issue_ack_o),
        .issue_rob_idx_o     (issue_rob_idx_o),
        .issue_rs1_busy_o    (issue_rs1_busy_o),
        .issue_rs1_rob_idx_o (issue_rs1_rob_idx_o),
        .issue_rs2_busy_o    (issue_rs2_busy_o),
        .issue_rs2_rob_idx_o (issue_rs2_rob_idx_o),
        .wb_valid_i          (wb_valid_i),
        .wb_rob_idx_i        (wb_rob_idx_i),
        .wb_data_i           (wb_data_i),
        .commit_req_o        (commit_req_o),
        .commit_ack_i        (commit_ack_i),
        .commit_rd_o         (commit_rd_o),
        .commit_data_o       (commit_data_o)
    );

    initial begin : clk_gen
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;   // 40 ns period
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // ----------------------------------------
    // checking and run control
    // ----------------------------------------
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Checks failed");
        $finish;
    endtask

    task automatic next_cycle;
        @(posedge clk_i);
        #DRIVE_DLY;   // inputs change well clear of the edge
    endtask

    task automatic wait_issue_ack(input logic level);
        int n;
        n = 0;
        while ((issue_ack_o !== level) && (n < TIMEOUT)) begin
            next_cycle();
            n++;
        end
        if (issue_ack_o !== level) begin
            abort_run("timeout: issue_ack_o never reached the expected level");
        end
    endtask

    task automatic wait_commit_req(input logic level);
        int n;
        n = 0;
        while ((commit_req_o !== level) && (n < TIMEOUT)) begin
            next_cycle();
            n++;
        end
        if (commit_req_o !== level) begin
            abort_run("timeout: commit_req_o never reached the expected level");
        end
    endtask

    // ----------------------------------------
    // operations
    // ----------------------------------------
    task automatic start_issue;
        issue_rd_i  = reg_idx_t'(iss_rd);
        issue_rs1_i = reg_idx_t'(iss_rs1);
        issue_rs2_i = reg_idx_t'(iss_rs2);
        issue_req_i = 1'b1;
        start_cyc   = cycle_cnt;
    endtask

    task automatic finish_issue(input logic check_lat);
        wait_issue_ack(1'b1);
        if (check_lat) begin   // latency only fixed when the rob had room
            check_value(cycle_cnt - start_cyc, ISSUE_LAT, "issue ack latency");
        end
        check_value(issue_rob_idx_o, exp_tag, "issue tag");
        check_value(issue_rs1_busy_o, exp_b1, "rs1 busy");
        if (exp_b1 != 0) check_value(issue_rs1_rob_idx_o, exp_t1, "rs1 producer tag");
        check_value(issue_rs2_busy_o, exp_b2, "rs2 busy");
        if (exp_b2 != 0) check_value(issue_rs2_rob_idx_o, exp_t2, "rs2 producer tag");
        issue_req_i = 1'b0;
        wait_issue_ack(1'b0);   // four-phase, back to idle
    endtask

    task automatic run_issue;
        iss_full = (occ == DEPTH);
        occ++;
        if (hold_cnt > 0) begin
            hold_cnt--;
            if (hold_cnt == 0) begin
                pending = 1'b1;   // started by the next commit
                return;
            end
        end
        start_issue();
        finish_issue(!iss_full);
    endtask

    task automatic run_writeback(input int tag, input logic [31:0] value);
        wb_valid_i   = 1'b1;   // single-cycle pulse
        wb_rob_idx_i = rob_idx_t'(tag);
        wb_data_i    = value;
        next_cycle();
        wb_valid_i = 1'b0;
    endtask

    task automatic run_commit(input int exp_rd, input logic [31:0] exp_val);
        int delay;
        int i;
        wait_commit_req(1'b1);
        check_value(commit_rd_o, exp_rd, "commit rd");
        check_value(commit_data_o, exp_val, "commit data");
        delay = $urandom % 4;
        repeat (delay) next_cycle();
        if (pending) begin
            start_issue();
            if (iss_full) begin
                // no room, ack must stay low until the pop
                for (i = 0; i < WATCH_WIN; i++) begin
                    next_cycle();
                    check_value(issue_ack_o, 1'b0, "issue ack while rob full");
                end
            end else begin
                repeat (2) next_cycle();   // ack lands in the allocate cycle
            end
        end
        commit_ack_i = 1'b1;
        wait_commit_req(1'b0);
        commit_ack_i = 1'b0;
        occ--;
        if (pending) begin
            pending = 1'b0;
            finish_issue(!iss_full);
        end
    endtask

    task automatic run_flush;
        int i;
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        occ     = 0;
        pending = 1'b0;
        for (i = 0; i < WATCH_WIN; i++) begin   // empty rob, nothing to commit
            next_cycle();
            check_value(commit_req_o, 1'b0, "commit request after flush");
        end
    endtask

    task automatic bad_line(input string kind);
        errors++;
        $display("malformed %s line in the operation file", kind);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main
        int             fd;
        int             code;
        int             tag;
        logic [7:0]     op;
        logic [31:0]    val;
        logic [1023:0]  line_buf;

        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        issue_req_i  = 1'b0;
        issue_rd_i   = '0;
        issue_rs1_i  = '0;
        issue_rs2_i  = '0;
        wb_valid_i   = 1'b0;
        wb_rob_idx_i = '0;
        wb_data_i    = '0;
        commit_ack_i = 1'b0;
        void'($urandom(SEED));   // one seed for the whole run

        fd = $fopen("verification/ooo_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/ooo_input.txt");
        end else begin
            repeat (3) @(posedge clk_i);
            #DRIVE_DLY;
            rst_n_i = 1'b1;
            next_cycle();
            while ($fscanf(fd, " %c", op) == 1) begin
                case (op)
                    "#": code = $fgets(line_buf, fd);   // comment line
                    "I": begin
                        code = $fscanf(fd, "%d %d %d %d %d %d %d %d", iss_rd, iss_rs1,
                                       iss_rs2, exp_tag, exp_b1, exp_t1, exp_b2, exp_t2);
                        if (code != 8) bad_line("issue");
                        else run_issue();
                    end
                    "W": begin
                        code = $fscanf(fd, "%d %h", tag, val);
                        if (code != 2) bad_line("writeback");
                        else run_writeback(tag, val);
                    end
                    "C": begin
                        code = $fscanf(fd, "%d %h", tag, val);
                        if (code != 2) bad_line("commit");
                        else run_commit(tag, val);
                    end
                    "F": run_flush();
                    "H": begin
                        code = $fscanf(fd, "%d", hold_cnt);
                        if (code != 1) bad_line("hold");
                    end
                    default: begin
                        errors++;
                        $display("unknown operation %c in the operation file", op);
                    end
                endcase
            end
            $fclose(fd);
            $display("checks run: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

// ==== verification/ooo_input.txt ====
# I rd rs1 rs2 tag rs1_busy rs1_tag rs2_busy rs2_tag | W tag value | C rd value (hex values)
# F flush | H n: commit ack held over the next n issues, the last one overlaps the next commit
# tags in order, operand status, out-of-order writeback
I 5 0 0 0 0 0 0 0
I 6 5 0 1 1 0 0 0
I 5 5 6 2 1 0 1 1
I 7 5 6 3 1 2 1 1
W 2 aaaa0002
W 1 aaaa0001
W 0 aaaa0000
C 5 aaaa0000
I 1 5 7 4 1 2 1 3
C 6 aaaa0001
C 5 aaaa0002
I 2 5 6 5 0 0 0 0
# issue and commit of x7 in the same cycle
W 3 aaaa0003
H 1
I 7 0 2 6 0 0 1 5
C 7 aaaa0003
I 3 7 1 7 1 6 1 4
W 6 aaaa0006
W 4 aaaa0004
W 5 aaaa0005
C 1 aaaa0004
C 2 aaaa0005
C 7 aaaa0006
I 4 7 3 0 0 0 1 7
# done entry behind an unfinished head, then flush
W 0 bbbb0000
F
# fill the rob with ack held, ninth issue waits for a commit
H 9
I 3 4 3 0 0 0 0 0
I 4 3 0 1 1 0 0 0
W 0 cccc0000
I 8 0 0 2 0 0 0 0
I 9 0 0 3 0 0 0 0
I 10 0 0 4 0 0 0 0
I 11 0 0 5 0 0 0 0
I 12 0 0 6 0 0 0 0
I 13 0 0 7 0 0 0 0
I 3 3 13 0 0 0 1 7
C 3 cccc0000
F
I 1 3 13 0 0 0 0 0

// ==== filelist.f ====
+incdir+common
common/ooo_pkg.sv
common/ooo_if.sv
regstat/updown_counter.sv
regstat/int_regstat.sv
source/reorder_buffer.sv
source/issue_commit_ctrl.sv
source/ooo_core_top.sv
verification/tb_ooo_core.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - include_dirs:
      - common
    files:
      - common/ooo_pkg.sv
      - common/ooo_if.sv
      - regstat/updown_counter.sv
      - regstat/int_regstat.sv
      - source/reorder_buffer.sv
      - source/issue_commit_ctrl.sv
      - source/ooo_core_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_ooo_core.sv
